// ==== periph_sys.f ====
hw/periph_pkg.sv
hw/reg_decoder.sv
hw/uart_core.sv
hw/spi_master.sv
hw/periph_top.sv
tests/periph_assert.sv
tests/periph_tb.sv

// ==== Bender.yml ====
package:
  name: periph_sys

sources:
  - files:
      - hw/periph_pkg.sv
      - hw/reg_decoder.sv
      - hw/uart_core.sv
      - hw/spi_master.sv
      - hw/periph_top.sv
  - target: test
    files:
      - tests/periph_assert.sv
      - tests/periph_tb.sv

// ==== tests/periph_stim.txt ====
# op addr wdata exp_rdata exp_err mask, all hex; op 1 writes, op 0 reads
# nonzero mask: read repeats until (rdata & mask) == (exp_rdata & mask)
# reset values
0 02 00 00 0 00
0 03 00 0F 0 00
0 13 00 03 0 00
0 12 00 00 0 00
0 11 00 00 0 00
# register read back and unmapped addresses
1 13 07 00 0 00
0 13 00 07 0 00
1 12 0A 00 0 00
0 12 00 0A 0 00
1 03 2C 00 0 00
0 03 00 2C 0 00
1 08 FF 00 1 00
0 08 00 00 1 00
0 20 00 00 1 00
1 14 55 00 1 00
0 13 00 07 0 00
0 12 00 0A 0 00
0 03 00 2C 0 00
# UART loopback
1 03 03 00 0 00
1 00 5A 00 0 00
0 02 00 02 0 03
0 01 00 5A 0 00
0 02 00 00 0 07
# UART overrun
1 00 C3 00 0 00
0 02 00 02 0 03
1 00 3C 00 0 00
0 02 00 04 0 04
0 02 00 02 0 07
0 01 00 3C 0 00
0 02 00 00 0 07
# SPI loopback
1 12 02 00 0 00
1 13 03 00 0 00
1 10 A5 00 0 00
0 11 00 01 0 00
0 11 00 00 0 01
0 11 00 02 0 00
0 10 00 A5 0 00
0 11 00 00 0 00

// ==== tests/periph_tb.sv ====
module periph_tb
    import periph_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_TIMEOUT  = 100;
    localparam int POLL_TIMEOUT = 2000;

    logic                        clk = 1'b0;
    logic                        arst_n;
    logic                        host_req;
    logic                        host_we;
    logic [DEF_ADDR_WIDTH-1:0]   host_addr;
    logic [DEF_DATA_WIDTH-1:0]   host_wdata;
    logic                        host_ack;
    logic [DEF_DATA_WIDTH-1:0]   host_rdata;
    logic                        host_err;
    logic                        uart_line;
    logic                        spi_line;
    logic                        spi_clk;
    logic [DEF_SPI_CS_WIDTH-1:0] spi_cs;

    logic [DEF_SPI_CS_WIDTH-1:0] cs_mask    = '0; // Last value written to the CS register.
    int                          spi_starts = 0;
    int                          spi_frames = 0;
    int                          sclk_rises = 0;
    logic                        sclk_prev  = 1'b0;
    logic                        cs_active  = 1'b0;

    int errors      = 0;
    int timeouts    = 0;
    int cycle_count = 0;
    bit aborted     = 1'b0;

    periph_top #(
        .ADDR_WIDTH  (DEF_ADDR_WIDTH),
        .DATA_WIDTH  (DEF_DATA_WIDTH),
        .SPI_CS_WIDTH(DEF_SPI_CS_WIDTH)
    ) uut (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .host_req_i  (host_req),
        .host_we_i   (host_we),
        .host_addr_i (host_addr),
        .host_wdata_i(host_wdata),
        .host_ack_o  (host_ack),
        .host_rdata_o(host_rdata),
        .host_err_o  (host_err),
        .uart_rx_i   (uart_line), // Loopback.
        .uart_tx_o   (uart_line),
        .spi_miso_i  (spi_line),  // Loopback.
        .spi_clk_o   (spi_clk),
        .spi_mosi_o  (spi_line),
        .spi_cs_o    (spi_cs)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // SPI pins move on rising edges, so they are looked at on falling ones.
    always @(negedge clk) begin
        if (arst_n) begin
            if (spi_cs != '1) begin
                assert (spi_cs == ~cs_mask) else begin
                    $display("Error: spi_cs_o expected %h, got %h", ~cs_mask, spi_cs);
                    errors++;
                end
                if (spi_clk && !sclk_prev) begin
                    sclk_rises++;
                end
            end else if (cs_active) begin
                spi_frames++; // Eight bits, one rising SCLK each.
                assert (sclk_rises == 8) else begin
                    $display("Error: spi_clk_o rising edges expected %h, got %h",
                             8, sclk_rises);
                    errors++;
                end
                sclk_rises = 0;
            end
            cs_active = spi_cs != '1;
            sclk_prev = spi_clk;
        end
    end

    // One four-phase access, entered 2 ns after a rising edge.
    task automatic host_access(input logic we, input logic [7:0] addr,
                               input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic err);
        int cycles;
        rdata      = '0;
        err        = 1'b0;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        cycles     = 0;
        while (!host_ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!host_ack) begin
            $display("Timeout: no ack for the access to address %h", addr);
            timeouts++;
            aborted  = 1'b1;
            host_req = 1'b0;
        end else begin
            rdata    = host_rdata;
            err      = host_err;
            host_req = 1'b0;
            cycles   = 0;
            while (host_ack && cycles < ACK_TIMEOUT) begin
                @(posedge clk);
                #2;
                cycles++;
            end
            if (host_ack) begin
                $display("Timeout: ack stayed high after req fell, address %h", addr);
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    // A nonzero mask polls the register until the masked bits match.
    task automatic apply_line(input logic [3:0] op, input logic [7:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp_rdata,
                              input logic [3:0] exp_err, input logic [31:0] mask);
        logic [31:0] rdata;
        logic        err;
        logic        matched;
        int          start;
        if (mask == '0) begin
            host_access(op[0], addr, wdata, rdata, err);
            if (!aborted) begin
                assert (err == exp_err[0]) else begin
                    $display("Error: host_err_o at %h expected %h, got %h", addr, exp_err[0], err);
                    errors++;
                end
                if (!op[0]) begin
                    assert (rdata == exp_rdata) else begin
                        $display("Error: host_rdata_o at %h expected %h, got %h",
                                 addr, exp_rdata, rdata);
                        errors++;
                    end
                end
                if (op[0] && addr == SPI_CS_ADDR) begin
                    cs_mask = wdata[DEF_SPI_CS_WIDTH-1:0];
                end
                if (op[0] && addr == SPI_DATA_ADDR) begin
                    spi_starts++;
                end
            end
        end else begin
            matched = 1'b0;
            start   = cycle_count;
            while (!matched && !aborted && cycle_count - start < POLL_TIMEOUT) begin
                host_access(1'b0, addr, '0, rdata, err);
                matched = (rdata & mask) == (exp_rdata & mask);
            end
            if (!matched && !aborted) begin
                $display("Timeout: address %h never matched %h under mask %h",
                         addr, exp_rdata, mask);
                timeouts++;
                aborted = 1'b1;
            end else if (matched) begin
                assert (err == exp_err[0]) else begin
                    $display("Error: host_err_o at %h expected %h, got %h", addr, exp_err[0], err);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          lines;
        string       line;
        logic [3:0]  op;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic [3:0]  exp_err;
        logic [31:0] mask;
        lines      = 0;
        arst_n     = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        fd = $fopen("tests/periph_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/periph_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !aborted) begin
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                op, addr, wdata, exp_rdata, exp_err, mask);
                    if (n == 6) begin // Comment and blank lines are skipped.
                        apply_line(op, addr, wdata, exp_rdata, exp_err, mask);
                        lines++;
                    end
                end
            end
            $fclose(fd);
            if (lines == 0) begin
                $display("The stimulus file held no accesses");
                errors++;
            end
        end
        assert (spi_frames == spi_starts) else begin
            $display("Error: spi_cs_o frames expected %h, got %h", spi_starts, spi_frames);
            errors++;
        end
        $display("Ran %0d accesses: %0d errors, %0d timeouts", lines, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/periph_assert.sv ====
module periph_assert #(
    parameter int ADDR_WIDTH   = 8,
    parameter int DATA_WIDTH   = 32,
    parameter int SPI_CS_WIDTH = 4
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    req_i,
    input  logic                    we_i,
    input  logic [ADDR_WIDTH-1:0]   addr_i,
    input  logic [DATA_WIDTH-1:0]   wdata_i,
    input  logic                    ack_i,
    input  logic                    err_i,
    input  logic                    sclk_i,
    input  logic [SPI_CS_WIDTH-1:0] cs_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Ack only drops once the host has released req.
    ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(ack_i) |-> !$past(req_i))
        else $error("ack fell while req was still high");

    req_rise_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(req_i) |-> !ack_i)
        else $error("req rose before ack of the previous access was low");

    // Req only drops once ack has been raised.
    req_held_until_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(req_i) |-> ack_i)
        else $error("req fell before ack was raised");

    // Address, direction and data hold while req is held.
    req_fields_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_i && $past(req_i) |-> $stable(addr_i) && $stable(we_i) && $stable(wdata_i))
        else $error("host request fields changed while req was held");

    err_needs_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        err_i |-> ack_i)
        else $error("err was raised without ack");

    cs_idle_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> (&cs_i) && !sclk_i)
        else $error("SPI chip select or clock active during reset");

    // Chip selects only move while SCLK is low.
    cs_stable_sclk_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $changed(cs_i) |-> !sclk_i)
        else $error("SPI chip select changed while SCLK was high");

endmodule

bind periph_top periph_assert #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .SPI_CS_WIDTH(SPI_CS_WIDTH)
) i_periph_assert (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (host_req_i),
    .we_i    (host_we_i),
    .addr_i  (host_addr_i),
    .wdata_i (host_wdata_i),
    .ack_i   (host_ack_o),
    .err_i   (host_err_o),
    .sclk_i  (spi_clk_o),
    .cs_i    (spi_cs_o)
);

// ==== hw/periph_top.sv ====
module periph_top
    import periph_pkg::*;
#(
    parameter int ADDR_WIDTH   = DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH   = DEF_DATA_WIDTH,
    parameter int SPI_CS_WIDTH = DEF_SPI_CS_WIDTH
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,

    input  logic                    host_req_i,
    input  logic                    host_we_i,
    input  logic [ADDR_WIDTH-1:0]   host_addr_i,
    input  logic [DATA_WIDTH-1:0]   host_wdata_i,
    output logic                    host_ack_o,
    output logic [DATA_WIDTH-1:0]   host_rdata_o,
    output logic                    host_err_o,

    input  logic                    uart_rx_i,
    output logic                    uart_tx_o,

    input  logic                    spi_miso_i,
    output logic                    spi_clk_o,
    output logic                    spi_mosi_o,
    output logic [SPI_CS_WIDTH-1:0] spi_cs_o
);

    logic       uart_wr;
    logic       uart_rd;
    logic       spi_wr;
    logic       spi_rd;
    logic [1:0] reg_addr;
    logic [7:0] reg_wdata;
    logic [7:0] uart_rdata;
    logic [7:0] spi_rdata;

    reg_decoder #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) i_reg_decoder (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .host_req_i  (host_req_i),
        .host_we_i   (host_we_i),
        .host_addr_i (host_addr_i),
        .host_wdata_i(host_wdata_i),
        .host_ack_o  (host_ack_o),
        .host_rdata_o(host_rdata_o),
        .host_err_o  (host_err_o),
        .uart_rdata_i(uart_rdata),
        .spi_rdata_i (spi_rdata),
        .uart_wr_o   (uart_wr),
        .uart_rd_o   (uart_rd),
        .spi_wr_o    (spi_wr),
        .spi_rd_o    (spi_rd),
        .reg_addr_o  (reg_addr),
        .reg_wdata_o (reg_wdata)
    );

    uart_core i_uart_core (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .wr_i    (uart_wr),
        .rd_i    (uart_rd),
        .addr_i  (reg_addr),
        .wdata_i (reg_wdata),
        .rx_i    (uart_rx_i),
        .rdata_o (uart_rdata),
        .tx_o    (uart_tx_o)
    );

    spi_master #(
        .SPI_CS_WIDTH(SPI_CS_WIDTH)
    ) i_spi_master (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .wr_i    (spi_wr),
        .rd_i    (spi_rd),
        .addr_i  (reg_addr),
        .wdata_i (reg_wdata),
        .miso_i  (spi_miso_i),
        .rdata_o (spi_rdata),
        .sclk_o  (spi_clk_o),
        .mosi_o  (spi_mosi_o),
        .cs_o    (spi_cs_o)
    );

endmodule

// ==== hw/spi_master.sv ====
module spi_master
    import periph_pkg::*;
#(
    parameter int SPI_CS_WIDTH = DEF_SPI_CS_WIDTH
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    wr_i,
    input  logic                    rd_i,
    input  logic [1:0]              addr_i,
    input  logic [7:0]              wdata_i,
    input  logic                    miso_i,
    output logic [7:0]              rdata_o,
    output logic                    sclk_o,
    output logic                    mosi_o,
    output logic [SPI_CS_WIDTH-1:0] cs_o
);

    logic [7:0]              div_q;
    logic [SPI_CS_WIDTH-1:0] mask_q;

    logic       start;
    logic       half_tick;
    logic       busy_q;
    logic       done_q;
    logic       sclk_q;
    logic [7:0] half_cnt_q;
    logic [4:0] edge_q;
    logic [7:0] shift_q;
    logic       miso_q;

    assign start     = wr_i && addr_i == SPI_DATA_ADDR[1:0] && !busy_q;
    assign half_tick = busy_q && half_cnt_q == div_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q  <= DEF_SPI_DIV;
            mask_q <= '0;
        end else if (wr_i) begin
            if (addr_i == SPI_DIV_ADDR[1:0]) begin
                div_q <= wdata_i;
            end
            if (addr_i == SPI_CS_ADDR[1:0]) begin
                mask_q <= wdata_i[SPI_CS_WIDTH-1:0];
            end
        end
    end

    // 16 SCLK edges, then one idle half period before CS releases.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            sclk_q     <= 1'b0;
            half_cnt_q <= '0;
            edge_q     <= '0;
        end else if (start) begin
            busy_q     <= 1'b1;
            done_q     <= 1'b0;
            half_cnt_q <= '0;
            edge_q     <= '0;
        end else if (busy_q) begin
            if (half_tick) begin
                half_cnt_q <= '0;
                if (edge_q == 5'd16) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    sclk_q <= ~sclk_q;
                    edge_q <= edge_q + 5'd1;
                end
            end else begin
                half_cnt_q <= half_cnt_q + 8'd1;
            end
        end else if (rd_i && addr_i == SPI_DATA_ADDR[1:0]) begin
            done_q <= 1'b0;
        end
    end

    // MISO is held from the rising edge and shifted in on the falling one.
    always_ff @(posedge clk_i) begin
        if (start) begin
            shift_q <= wdata_i;
        end else if (half_tick && edge_q != 5'd16) begin
            if (!sclk_q) begin
                miso_q <= miso_i;
            end else begin
                shift_q <= {shift_q[6:0], miso_q};
            end
        end
    end

    assign sclk_o = sclk_q;
    assign mosi_o = busy_q & shift_q[7]; // MSB first.
    assign cs_o   = busy_q ? ~mask_q : '1;

    always_comb begin
        rdata_o = '0;
        case (addr_i)
            SPI_DATA_ADDR[1:0]:   rdata_o = shift_q;
            SPI_STATUS_ADDR[1:0]: begin
                rdata_o[SPI_ST_BUSY] = busy_q;
                rdata_o[SPI_ST_DONE] = done_q;
            end
            SPI_CS_ADDR[1:0]:     rdata_o = 8'(mask_q);
            default:              rdata_o = div_q;
        endcase
    end

endmodule

// ==== hw/uart_core.sv ====
module uart_core
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       wr_i,
    input  logic       rd_i,
    input  logic [1:0] addr_i,
    input  logic [7:0] wdata_i,
    input  logic       rx_i,
    output logic [7:0] rdata_o,
    output logic       tx_o
);

    logic [15:0] div_q;

    logic        tx_start;
    logic        tx_busy_q;
    logic [9:0]  tx_shift_q;
    logic [15:0] tx_cnt_q;
    logic [3:0]  tx_bit_q;

    logic [1:0]  rx_sync_q;
    logic        rx_busy_q;
    logic [15:0] rx_cnt_q;
    logic [3:0]  rx_bit_q;
    logic [7:0]  rx_shift_q;
    logic [7:0]  rx_data_q;
    logic        rx_valid_q;
    logic        rx_overrun_q;
    logic        rx_sample;
    logic        rx_done;
    logic        rd_data;
    logic        rd_status;

    assign tx_start  = wr_i && addr_i == UART_TXDATA_ADDR[1:0] && !tx_busy_q;
    assign rd_data   = rd_i && addr_i == UART_RXDATA_ADDR[1:0];
    assign rd_status = rd_i && addr_i == UART_STATUS_ADDR[1:0];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q <= DEF_UART_DIV;
        end else if (wr_i && addr_i == UART_DIV_ADDR[1:0]) begin
            div_q[7:0] <= wdata_i;
        end
    end

    // Frame is start, eight data bits LSB first, stop.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_busy_q  <= 1'b0;
            tx_shift_q <= '1; // Line idles high.
            tx_cnt_q   <= '0;
            tx_bit_q   <= '0;
        end else if (tx_start) begin
            tx_busy_q  <= 1'b1;
            tx_shift_q <= {1'b1, wdata_i, 1'b0};
            tx_cnt_q   <= '0;
            tx_bit_q   <= '0;
        end else if (tx_busy_q) begin
            if (tx_cnt_q == div_q) begin
                tx_cnt_q   <= '0;
                tx_shift_q <= {1'b1, tx_shift_q[9:1]};
                tx_bit_q   <= tx_bit_q + 4'd1;
                if (tx_bit_q == 4'd9) begin
                    tx_busy_q <= 1'b0;
                end
            end else begin
                tx_cnt_q <= tx_cnt_q + 16'd1;
            end
        end
    end

    assign tx_o = tx_shift_q[0];

    // Half a period into the start bit, then a full period per bit.
    assign rx_sample = rx_busy_q &&
                       rx_cnt_q == ((rx_bit_q == 4'd0) ? (div_q >> 1) : div_q);
    assign rx_done   = rx_sample && rx_bit_q == 4'd9;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_sync_q <= '1;
            rx_busy_q <= 1'b0;
            rx_cnt_q  <= '0;
            rx_bit_q  <= '0;
        end else begin
            rx_sync_q <= {rx_sync_q[0], rx_i};
            if (!rx_busy_q) begin
                if (!rx_sync_q[1]) begin
                    rx_busy_q <= 1'b1;
                    rx_cnt_q  <= '0;
                    rx_bit_q  <= '0;
                end
            end else if (rx_sample) begin
                rx_cnt_q <= '0;
                rx_bit_q <= rx_bit_q + 4'd1;
                if ((rx_bit_q == 4'd0 && rx_sync_q[1]) || rx_bit_q == 4'd9) begin
                    rx_busy_q <= 1'b0; // Glitch on the start bit, or frame end.
                end
            end else begin
                rx_cnt_q <= rx_cnt_q + 16'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_sample && rx_bit_q != 4'd0 && rx_bit_q != 4'd9) begin
            rx_shift_q <= {rx_sync_q[1], rx_shift_q[7:1]};
        end
        if (rx_done) begin
            rx_data_q <= rx_shift_q;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_valid_q   <= 1'b0;
            rx_overrun_q <= 1'b0;
        end else begin
            if (rx_done) begin
                rx_valid_q <= 1'b1;
            end else if (rd_data) begin
                rx_valid_q <= 1'b0;
            end
            if (rx_done && rx_valid_q && !rd_data) begin
                rx_overrun_q <= 1'b1; // Previous byte was never read.
            end else if (rd_status) begin
                rx_overrun_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        case (addr_i)
            UART_RXDATA_ADDR[1:0]: rdata_o = rx_data_q;
            UART_STATUS_ADDR[1:0]: begin
                rdata_o[UART_ST_TX_BUSY]    = tx_busy_q;
                rdata_o[UART_ST_RX_VALID]   = rx_valid_q;
                rdata_o[UART_ST_RX_OVERRUN] = rx_overrun_q;
            end
            UART_DIV_ADDR[1:0]:    rdata_o = div_q[7:0];
            default:               rdata_o = '0;
        endcase
    end

endmodule

// ==== hw/reg_decoder.sv ====
module reg_decoder
    import periph_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH = DEF_DATA_WIDTH
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    input  logic                  host_req_i,
    input  logic                  host_we_i,
    input  logic [ADDR_WIDTH-1:0] host_addr_i,
    input  logic [DATA_WIDTH-1:0] host_wdata_i,
    output logic                  host_ack_o,
    output logic [DATA_WIDTH-1:0] host_rdata_o,
    output logic                  host_err_o,

    input  logic [7:0]            uart_rdata_i,
    input  logic [7:0]            spi_rdata_i,
    output logic                  uart_wr_o,
    output logic                  uart_rd_o,
    output logic                  spi_wr_o,
    output logic                  spi_rd_o,
    output logic [1:0]            reg_addr_o,
    output logic [7:0]            reg_wdata_o
);

    // Each peripheral owns a block of four words.
    localparam logic [ADDR_WIDTH-1:0] UART_BASE = ADDR_WIDTH'(UART_TXDATA_ADDR);
    localparam logic [ADDR_WIDTH-1:0] SPI_BASE  = ADDR_WIDTH'(SPI_DATA_ADDR);

    logic       access;
    logic       uart_sel;
    logic       spi_sel;
    logic [7:0] sel_rdata;

    // High only on the first edge of a request, since ack follows it.
    assign access = host_req_i & ~host_ack_o;

    assign uart_sel = (host_addr_i >> 2) == (UART_BASE >> 2);
    assign spi_sel  = (host_addr_i >> 2) == (SPI_BASE >> 2);

    assign uart_wr_o = access & host_we_i & uart_sel;
    assign uart_rd_o = access & ~host_we_i & uart_sel;
    assign spi_wr_o  = access & host_we_i & spi_sel;
    assign spi_rd_o  = access & ~host_we_i & spi_sel;

    assign reg_addr_o  = host_addr_i[1:0];
    assign reg_wdata_o = host_wdata_i[7:0];

    always_comb begin
        sel_rdata = '0; // Unmapped reads return zero.
        if (uart_sel) begin
            sel_rdata = uart_rdata_i;
        end else if (spi_sel) begin
            sel_rdata = spi_rdata_i;
        end
    end

    // Four-phase ack. Err is only ever seen together with ack.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            host_ack_o <= 1'b0;
            host_err_o <= 1'b0;
        end else if (access) begin
            host_ack_o <= 1'b1;
            host_err_o <= ~(uart_sel | spi_sel);
        end else if (!host_req_i) begin
            host_ack_o <= 1'b0;
            host_err_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            host_rdata_o <= DATA_WIDTH'(sel_rdata);
        end
    end

endmodule

// ==== hw/periph_pkg.sv ====
package periph_pkg;

    // UART register map.
    localparam logic [7:0] UART_TXDATA_ADDR = 8'h00;
    localparam logic [7:0] UART_RXDATA_ADDR = 8'h01;
    localparam logic [7:0] UART_STATUS_ADDR = 8'h02;
    localparam logic [7:0] UART_DIV_ADDR    = 8'h03;

    // SPI register map.
    localparam logic [7:0] SPI_DATA_ADDR   = 8'h10;
    localparam logic [7:0] SPI_STATUS_ADDR = 8'h11;
    localparam logic [7:0] SPI_CS_ADDR     = 8'h12;
    localparam logic [7:0] SPI_DIV_ADDR    = 8'h13;

    localparam int DEF_ADDR_WIDTH   = 8;
    localparam int DEF_DATA_WIDTH   = 32;
    localparam int DEF_SPI_CS_WIDTH = 4;

    localparam logic [15:0] DEF_UART_DIV = 16'd15;
    localparam logic [7:0]  DEF_SPI_DIV  = 8'd3;

    // Status bit positions.
    localparam int UART_ST_TX_BUSY    = 0;
    localparam int UART_ST_RX_VALID   = 1;
    localparam int UART_ST_RX_OVERRUN = 2;
    localparam int SPI_ST_BUSY        = 0;
    localparam int SPI_ST_DONE        = 1; // Cleared by a read of DATA.

endpackage
